/* rtl/spritePkg.sv */
package spritePkg;

	// Slot counter, one round is 32 cycles of CLK_24M
	localparam int slotBits = 5;

	// Window boundaries, first and last slot of each
	localparam logic [slotBits-1:0] listFirst = 5'd0; // Active list read
	localparam logic [slotBits-1:0] listLast  = 5'd3;
	localparam logic [slotBits-1:0] scb2First = 5'd4; // Shrink
	localparam logic [slotBits-1:0] scb2Last  = 5'd6;
	localparam logic [slotBits-1:0] scb3First = 5'd7; // Y, sticky, size
	localparam logic [slotBits-1:0] scb3Last  = 5'd9;
	localparam logic [slotBits-1:0] scb4First = 5'd10; // X
	localparam logic [slotBits-1:0] scb4Last  = 5'd12;
	localparam logic [slotBits-1:0] cpuFirst  = 5'd13; // CPU access
	localparam logic [slotBits-1:0] cpuLast   = 5'd15;

	// Parse windows are back to back from parseFirst
	localparam logic [slotBits-1:0] parseFirst = 5'd16;
	localparam int parseLen   = 3; // Slots per parse window
	localparam int parseCount = 5; // Windows per round, slot 31 left idle

	// Fast VRAM geometry
	localparam int addrBits = 11;
	localparam int dataBits = 16;

	// Region bases
	localparam logic [addrBits-1:0] scb2Base = 11'h000;
	localparam logic [addrBits-1:0] scb3Base = 11'h200;
	localparam logic [addrBits-1:0] scb4Base = 11'h400;
	localparam logic [addrBits-1:0] listBase = 11'h600; // Bank 0 here, bank 1 at +$80

	localparam int spriteBits = 9; // Sprite number
	localparam int listBits   = 7; // Entry index inside one list bank

	// SCB3 word layout
	localparam int yLsb      = 7; // Y at 14:7
	localparam int stickyBit = 6;
	localparam int sizeBits  = 6; // Height at 5:0

	// SCB4 word layout, X at 15:7
	localparam int xLsb = 7;

	// SCB2 shrink field
	localparam int shrinkBits = 12;

endpackage

/* rtl/fastVram.sv */
`timescale 1ns/1ps

module fastVram
(
	input  logic                            CLK_24M,
	input  logic [spritePkg::addrBits-1:0] vramAddr,
	input  logic [spritePkg::dataBits-1:0] vramWrData,
	input  logic                            vramWe,
	output logic [spritePkg::dataBits-1:0] vramRdData
);

	localparam int depth = 1 << spritePkg::addrBits; // 2K words

	logic [spritePkg::dataBits-1:0] mem [0:depth-1];

	// Start from a blank part
	initial
	begin
		for (int i = 0; i < depth; i++)
			mem[i] = '0;
	end

	// Single port, read registered every cycle
	always_ff @(posedge CLK_24M)
	begin
		if (vramWe)
			mem[vramAddr] <= vramWrData;
		vramRdData <= mem[vramAddr]; // Old word on a write cycle
	end

endmodule

/* rtl/slotSequencer.sv */
`timescale 1ns/1ps

module slotSequencer
(
	input  logic                              CLK_24M,
	input  logic                              TEST,
	output logic [spritePkg::slotBits-1:0]   slot,

	// Render side
	input  logic [spritePkg::addrBits-1:0]   listAddr,
	input  logic [spritePkg::spriteBits-1:0] renderIdx,

	// CPU side
	input  logic [spritePkg::addrBits-1:0]   cpuPtr,
	input  logic [spritePkg::dataBits-1:0]   cpuWrData,
	input  logic                              cpuWe,

	// Parser side
	input  logic [spritePkg::addrBits-1:0]   parseAddr,
	input  logic [spritePkg::dataBits-1:0]   parseWrData,
	input  logic                              parseWe,

	// To the RAM
	output logic [spritePkg::addrBits-1:0]   vramAddr,
	output logic [spritePkg::dataBits-1:0]   vramWrData,
	output logic                              vramWe
);

	localparam int parseEnd =
		spritePkg::parseFirst + spritePkg::parseLen * spritePkg::parseCount - 1;

	logic inList;
	logic inScb2;
	logic inScb3;
	logic inScb4;
	logic inCpu;
	logic inParse;
	logic parseLastCyc; // Final slot of one parse window

	// Free running, wraps every 32 cycles
	always_ff @(posedge CLK_24M or posedge TEST)
	begin
		if (TEST)
			slot <= '0;
		else
			slot <= slot + 1'b1;
	end

	// Window decode
	assign inList  = slot inside {[spritePkg::listFirst : spritePkg::listLast]};
	assign inScb2  = slot inside {[spritePkg::scb2First : spritePkg::scb2Last]};
	assign inScb3  = slot inside {[spritePkg::scb3First : spritePkg::scb3Last]};
	assign inScb4  = slot inside {[spritePkg::scb4First : spritePkg::scb4Last]};
	assign inCpu   = slot inside {[spritePkg::cpuFirst : spritePkg::cpuLast]};
	assign inParse = slot inside {[spritePkg::parseFirst : parseEnd]};

	assign parseLastCyc = inParse &&
		((int'(slot) - spritePkg::parseFirst) % spritePkg::parseLen == spritePkg::parseLen - 1);

	// Address, data and write enable per window
	always_comb
	begin
		vramAddr   = parseAddr; // Parse windows and idle slot 31
		vramWrData = parseWrData;
		vramWe     = 1'b0;
		if (inList)
			vramAddr = listAddr;
		else if (inScb2)
			vramAddr = spritePkg::scb2Base + renderIdx;
		else if (inScb3)
			vramAddr = spritePkg::scb3Base + renderIdx;
		else if (inScb4)
			vramAddr = spritePkg::scb4Base + renderIdx;
		else if (inCpu)
		begin
			vramAddr   = cpuPtr;
			vramWrData = cpuWrData;
			vramWe     = cpuWe && (slot == spritePkg::cpuLast); // Only at slot 15
		end
		else if (inParse)
			vramWe = parseWe && parseLastCyc; // Write modes only, last cycle
	end

endmodule

/* rtl/spriteParser.sv */
`timescale 1ns/1ps

module spriteParser
(
	input  logic                            CLK_24M,
	input  logic                            TEST,
	input  logic [spritePkg::slotBits-1:0] slot,
	input  logic [8:0]                      vCount,
	input  logic                            chbl,
	input  logic                            bFlip,
	input  logic [spritePkg::dataBits-1:0] vramRdData,
	output logic [spritePkg::addrBits-1:0] parseAddr,
	output logic [spritePkg::dataBits-1:0] parseWrData,
	output logic                            parseWe
);

	localparam int parseEnd =
		spritePkg::parseFirst + spritePkg::parseLen * spritePkg::parseCount - 1;

	// Mode encoding
	localparam logic [1:0] modeLatchA = 2'b00;
	localparam logic [1:0] modeLatchB = 2'b01;
	localparam logic [1:0] modeWriteA = 2'b10;
	localparam logic [1:0] modeWriteB = 2'b11;

	logic [1:0]                        mode;
	logic [spritePkg::spriteBits-1:0] parseCounter; // Sprite under test
	logic [spritePkg::listBits-1:0]   writeCounter; // Next free list entry
	logic [spritePkg::spriteBits-1:0] latchA;
	logic [spritePkg::spriteBits-1:0] latchB;
	logic [spritePkg::spriteBits-1:0] latchMux;
	logic                              windowEnd;
	logic                              yCarry; // Line falls inside the sprite

	assign windowEnd = (slot inside {[spritePkg::parseFirst : parseEnd]}) &&
		((int'(slot) - spritePkg::parseFirst) % spritePkg::parseLen == spritePkg::parseLen - 1);

	// Y + line + 1 overflowing 8 bits means a hit
	assign yCarry = ({1'b0, vramRdData[spritePkg::yLsb +: 8]} + {1'b0, vCount[7:0]} + 9'd1)
		> 9'd255;

	// Read SCB3 while latching, write into the back bank otherwise
	assign parseAddr = mode[1]
		? spritePkg::listBase + {~bFlip, writeCounter}
		: spritePkg::scb3Base + parseCounter;

	assign latchMux    = mode[0] ? latchB : latchA;
	assign parseWrData = {{(spritePkg::dataBits - spritePkg::spriteBits){1'b0}}, latchMux};
	assign parseWe     = mode[1]; // Sequencer trims it to the last slot

	always_ff @(posedge CLK_24M or posedge TEST)
	begin
		if (TEST)
		begin
			mode         <= modeLatchA;
			parseCounter <= '0;
			writeCounter <= '0;
		end
		else
		begin
			if (windowEnd)
			begin
				case (mode)
					modeLatchA:
					begin
						parseCounter <= parseCounter + 1'b1;
						if (yCarry)
							mode <= modeLatchB;
					end
					modeLatchB:
					begin
						parseCounter <= parseCounter + 1'b1;
						if (yCarry)
							mode <= modeWriteA; // Pair complete
					end
					modeWriteA:
					begin
						writeCounter <= writeCounter + 1'b1;
						mode         <= modeWriteB;
					end
					default:
					begin
						writeCounter <= writeCounter + 1'b1;
						mode         <= modeLatchA; // Back to searching
					end
				endcase
			end
			// New line wins over any step above
			if (chbl)
			begin
				parseCounter <= '0;
				writeCounter <= '0;
			end
		end
	end

	// Matched sprite numbers
	always_ff @(posedge CLK_24M)
	begin
		if (windowEnd && yCarry)
		begin
			if (mode == modeLatchA)
				latchA <= parseCounter;
			if (mode == modeLatchB)
				latchB <= parseCounter;
		end
	end

endmodule

/* rtl/renderFetch.sv */
`timescale 1ns/1ps

module renderFetch
(
	input  logic                                        CLK_24M,
	input  logic                                        TEST,
	input  logic [spritePkg::slotBits-1:0]             slot,
	input  logic [8:0]                                  vCount,
	input  logic                                        chbl,
	input  logic                                        bFlip,
	input  logic [spritePkg::dataBits-1:0]             vramRdData,
	output logic [spritePkg::addrBits-1:0]             listAddr,
	output logic [spritePkg::spriteBits-1:0]           renderIdx,
	output logic [spritePkg::shrinkBits-1:0]           attrShrink,
	output logic [4:0]                                  tileIdx,
	output logic [3:0]                                  tileLine,
	output logic [spritePkg::dataBits-spritePkg::xLsb-1:0] attrXPos
);

	logic [spritePkg::listBits-1:0] readCounter; // Entry in the front bank
	logic [7:0]                      ySum;
	logic                            yCarry;
	logic                            attrSticky; // For the later chaining stage
	logic [spritePkg::sizeBits-1:0] attrSize;   // Height in tiles, same

	// Front bank is the one the parser is not filling
	assign listAddr = spritePkg::listBase + {bFlip, readCounter};

	// Same sum as the parser, here it gives the line inside the sprite
	assign {yCarry, ySum} = {1'b0, vramRdData[spritePkg::yLsb +: 8]} + {1'b0, vCount[7:0]} + 9'd1;

	always_ff @(posedge CLK_24M or posedge TEST)
	begin
		if (TEST)
		begin
			readCounter <= '0;
			renderIdx   <= '0;
			attrShrink  <= '0;
			tileIdx     <= '0;
			tileLine    <= '0;
			attrXPos    <= '0;
			attrSticky  <= 1'b0;
			attrSize    <= '0;
		end
		else
		begin
			case (slot)
				spritePkg::listLast:
					renderIdx <= vramRdData[spritePkg::spriteBits-1:0]; // List entry
				spritePkg::scb2Last:
					attrShrink <= vramRdData[spritePkg::shrinkBits-1:0];
				spritePkg::scb3Last:
				begin
					tileLine   <= ySum[3:0];
					tileIdx    <= {~yCarry, ySum[7:4]}; // Tile row in the column
					attrSticky <= vramRdData[spritePkg::stickyBit];
					attrSize   <= vramRdData[spritePkg::sizeBits-1:0];
				end
				spritePkg::scb4Last:
				begin
					attrXPos    <= vramRdData[spritePkg::dataBits-1:spritePkg::xLsb];
					readCounter <= readCounter + 1'b1; // On to the next entry
				end
				default:
				begin
				end
			endcase
			if (chbl)
				readCounter <= '0; // Start of line
		end
	end

endmodule

/* rtl/cpuVramPort.sv */
`timescale 1ns/1ps

module cpuVramPort
(
	input  logic                            CLK_24M,
	input  logic                            TEST,
	input  logic [spritePkg::slotBits-1:0] slot,
	input  logic [spritePkg::addrBits-1:0] cpuAddr,
	input  logic [spritePkg::dataBits-1:0] cpuWrData,
	input  logic                            cpuZone,
	input  logic                            cpuWrite,
	input  logic                            reloadReq,
	input  logic [spritePkg::addrBits-1:0] vramMod,
	input  logic [spritePkg::dataBits-1:0] vramRdData,
	output logic [spritePkg::addrBits-1:0] cpuPtr,
	output logic                            cpuWe,
	output logic [spritePkg::dataBits-1:0] cpuRdData,
	output logic                            cpuWriteAck,
	output logic [spritePkg::dataBits-1:0] cpuWrHold // Data for the sequencer
);

	logic pendWr;     // Strobe seen, waiting for slot 13
	logic pendReload;
	logic wrStrobe;

	assign wrStrobe = cpuWrite && cpuZone; // Outside the zone it is dropped

	always_ff @(posedge CLK_24M or posedge TEST)
	begin
		if (TEST)
		begin
			pendWr      <= 1'b0;
			pendReload  <= 1'b0;
			cpuWe       <= 1'b0;
			cpuPtr      <= '0;
			cpuWriteAck <= 1'b0;
		end
		else
		begin
			cpuWriteAck <= cpuWe && (slot == spritePkg::cpuLast); // Cycle after slot 15
			if (slot == spritePkg::cpuFirst)
			begin
				cpuWe      <= pendWr; // Arm this round's write
				pendWr     <= 1'b0;
				pendReload <= 1'b0;
				if (pendReload)
					cpuPtr <= cpuAddr;
			end
			if (cpuWe && (slot == spritePkg::cpuLast))
			begin
				cpuWe  <= 1'b0;
				cpuPtr <= cpuPtr + vramMod; // Wraps at 2K
			end
			// Late strobes stay for the next round
			if (wrStrobe)
				pendWr <= 1'b1;
			if (reloadReq)
				pendReload <= 1'b1;
		end
	end

	always_ff @(posedge CLK_24M)
	begin
		if (wrStrobe)
			cpuWrHold <= cpuWrData;
		if (slot == spritePkg::cpuLast)
			cpuRdData <= vramRdData; // Word at the pointer before this round's write
	end

endmodule

/* rtl/fastCycle.sv */
`timescale 1ns/1ps

module fastCycle
(
	input  logic                                        CLK_24M,
	input  logic                                        TEST,
	input  logic [8:0]                                  vCount,
	input  logic                                        chbl,
	input  logic                                        bFlip,
	input  logic [spritePkg::addrBits-1:0]             vramMod,
	input  logic                                        reloadReq,
	input  logic [spritePkg::addrBits-1:0]             cpuAddr,
	input  logic [spritePkg::dataBits-1:0]             cpuWrData,
	input  logic                                        cpuZone,
	input  logic                                        cpuWrite,
	output logic [spritePkg::dataBits-spritePkg::xLsb-1:0] attrXPos,
	output logic [spritePkg::spriteBits-1:0]           renderIdx,
	output logic [4:0]                                  tileIdx,
	output logic [3:0]                                  tileLine,
	output logic [spritePkg::shrinkBits-1:0]           attrShrink,
	output logic [spritePkg::dataBits-1:0]             cpuRdData,
	output logic                                        cpuWriteAck
);

	logic [spritePkg::slotBits-1:0] slot;
	logic [spritePkg::addrBits-1:0] vramAddr;
	logic [spritePkg::dataBits-1:0] vramWrData;
	logic                            vramWe;
	logic [spritePkg::dataBits-1:0] vramRdData;
	logic [spritePkg::addrBits-1:0] listAddr;
	logic [spritePkg::addrBits-1:0] cpuPtr;
	logic [spritePkg::dataBits-1:0] cpuWrHold;
	logic                            cpuWe;
	logic [spritePkg::addrBits-1:0] parseAddr;
	logic [spritePkg::dataBits-1:0] parseWrData;
	logic                            parseWe;

	slotSequencer sequencer (
		.CLK_24M(CLK_24M), .TEST(TEST), .slot(slot),
		.listAddr(listAddr), .renderIdx(renderIdx),
		.cpuPtr(cpuPtr), .cpuWrData(cpuWrHold), .cpuWe(cpuWe),
		.parseAddr(parseAddr), .parseWrData(parseWrData), .parseWe(parseWe),
		.vramAddr(vramAddr), .vramWrData(vramWrData), .vramWe(vramWe)
	);

	fastVram vram (
		.CLK_24M(CLK_24M), .vramAddr(vramAddr), .vramWrData(vramWrData),
		.vramWe(vramWe), .vramRdData(vramRdData)
	);

	// Builds the active list for the next line
	spriteParser parser (
		.CLK_24M(CLK_24M), .TEST(TEST), .slot(slot), .vCount(vCount),
		.chbl(chbl), .bFlip(bFlip), .vramRdData(vramRdData),
		.parseAddr(parseAddr), .parseWrData(parseWrData), .parseWe(parseWe)
	);

	renderFetch fetch (
		.CLK_24M(CLK_24M), .TEST(TEST), .slot(slot), .vCount(vCount),
		.chbl(chbl), .bFlip(bFlip), .vramRdData(vramRdData),
		.listAddr(listAddr), .renderIdx(renderIdx), .attrShrink(attrShrink),
		.tileIdx(tileIdx), .tileLine(tileLine), .attrXPos(attrXPos)
	);

	cpuVramPort cpuPort (
		.CLK_24M(CLK_24M), .TEST(TEST), .slot(slot), .cpuAddr(cpuAddr),
		.cpuWrData(cpuWrData), .cpuZone(cpuZone), .cpuWrite(cpuWrite),
		.reloadReq(reloadReq), .vramMod(vramMod), .vramRdData(vramRdData),
		.cpuPtr(cpuPtr), .cpuWe(cpuWe), .cpuRdData(cpuRdData),
		.cpuWriteAck(cpuWriteAck), .cpuWrHold(cpuWrHold)
	);

endmodule

/* verif/fastCycle_chk.sv */
`timescale 1ns/1ps

module fastCycle_chk
(
	input logic                            CLK_24M,
	input logic                            TEST,
	input logic [spritePkg::slotBits-1:0] slot,
	input logic                            vramWe
);

	// Writes only at the end of the CPU window or of a parse window
	weInWriteSlot: assert property (@(posedge CLK_24M) disable iff (TEST)
		vramWe |-> (slot inside {5'd15, 5'd18, 5'd21, 5'd24, 5'd27, 5'd30}))
		else $error("vramWe high in slot %0d", slot);

	// Steps by one, wraps at 32
	slotStep: assert property (@(posedge CLK_24M) disable iff (TEST)
		!$past(TEST) |-> slot == $past(slot) + 5'd1)
		else $error("slot jumped to %0d", slot);

endmodule

bind slotSequencer fastCycle_chk slotChk
(
	.CLK_24M(CLK_24M), .TEST(TEST), .slot(slot), .vramWe(vramWe)
);

/* verif/fastCycleTb.sv */
`timescale 1ns/1ps

module fastCycleTb;

	localparam int halfPeriod = 2; // 4 ns clock
	localparam int clkPeriod  = 2 * halfPeriod;
	// Rounds of reset, CPU, parser, bank swap and render tests
	localparam int testRounds = 2 + 50 + 45 + 42 + 40;
	localparam int watchdogNs = (testRounds * 32 + 200) * clkPeriod;
	localparam logic [spritePkg::addrBits-1:0] cpuBase = 11'h7A0; // Outside SCB and list areas
	localparam logic [spritePkg::addrBits-1:0] bank1   = spritePkg::listBase + 11'h080;

	logic                                        CLK_24M;
	logic                                        TEST;
	logic [8:0]                                  vCount;
	logic                                        chbl;
	logic                                        bFlip;
	logic [spritePkg::addrBits-1:0]             vramMod;
	logic                                        reloadReq;
	logic [spritePkg::addrBits-1:0]             cpuAddr;
	logic [spritePkg::dataBits-1:0]             cpuWrData;
	logic                                        cpuZone;
	logic                                        cpuWrite;
	logic [spritePkg::dataBits-spritePkg::xLsb-1:0] attrXPos;
	logic [spritePkg::spriteBits-1:0]           renderIdx;
	logic [4:0]                                  tileIdx;
	logic [3:0]                                  tileLine;
	logic [spritePkg::shrinkBits-1:0]           attrShrink;
	logic [spritePkg::dataBits-1:0]             cpuRdData;
	logic                                        cpuWriteAck;

	integer seed;
	int     errCount;
	int     testsPassed;
	int     testsFailed;
	int     hits [5] = '{3, 7, 8, 20, 41}; // Sprites that fall on line 100

	fastCycle UUT (.*);

	initial CLK_24M = 1'b0;
	always #halfPeriod CLK_24M = ~CLK_24M;

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("FAILED %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
			errCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		if (errCount == errBefore)
		begin
			testsPassed++;
			$display("%s: ok", name);
		end
		else
		begin
			testsFailed++;
			$display("%s: %0d errors", name, errCount - errBefore);
		end
	endtask

	task automatic waitSlot(input int n);
		@(negedge CLK_24M); // Always moves on at least one cycle
		while (UUT.slot != n)
			@(negedge CLK_24M);
	endtask

	// chbl high in slot 0, line settings from the same cycle
	task automatic startLine(input logic [8:0] v, input logic flip);
		waitSlot(31);
		@(posedge CLK_24M);
		chbl   <= 1'b1;
		vCount <= v;
		bFlip  <= flip;
		@(posedge CLK_24M);
		chbl <= 1'b0;
	endtask

	task automatic cpuWriteWord(input logic doReload, input logic [10:0] addr,
		input logic [15:0] data);
		int waited;
		@(posedge CLK_24M);
		cpuAddr   <= addr; // Held until the next call
		cpuWrData <= data;
		cpuWrite  <= 1'b1;
		reloadReq <= doReload;
		@(posedge CLK_24M);
		cpuWrite  <= 1'b0;
		reloadReq <= 1'b0;
		waited = 0;
		while (!cpuWriteAck && waited < 40)
		begin
			@(negedge CLK_24M);
			waited++;
		end
		if (!cpuWriteAck)
		begin
			$display("no write acknowledge within 40 cycles, address %0h at %0t ns", addr, $time);
			errCount++;
		end
	endtask

	// Reload, then two rounds for cpuRdData to follow the pointer
	task automatic cpuReadWord(input logic [10:0] addr, output logic [15:0] data);
		@(posedge CLK_24M);
		cpuAddr   <= addr;
		reloadReq <= 1'b1;
		@(posedge CLK_24M);
		reloadReq <= 1'b0;
		repeat (64) @(negedge CLK_24M);
		data = cpuRdData;
	endtask

	// SCB3 word with a chosen Y, rest random
	function automatic logic [15:0] yWord(input logic [7:0] y);
		logic [15:0] w;
		w = 16'($random(seed)) & 16'h807F;
		return w | ({8'd0, y} << spritePkg::yLsb);
	endfunction

	task automatic resetTest();
		int errBefore;
		errBefore = errCount;
		@(negedge CLK_24M); // Slot 0
		check("cpuWriteAck", 0, cpuWriteAck);
		check("renderIdx", 0, renderIdx);
		check("attrShrink", 0, attrShrink);
		check("tileIdx", 0, tileIdx);
		check("tileLine", 0, tileLine);
		check("attrXPos", 0, attrXPos);
		reportTest("reset values", errBefore);
	endtask

	task automatic cpuAccessTest();
		int          errBefore;
		int          i;
		int          acks;
		logic [15:0] written [10];
		logic [15:0] rd;
		errBefore = errCount;
		@(posedge CLK_24M);
		vramMod <= 11'd3;
		for (i = 0; i < 10; i++)
		begin
			written[i] = 16'($random(seed));
			cpuWriteWord(i == 0, cpuBase, written[i]); // Reload once, then step by 3
		end
		for (i = 0; i < 10; i++)
		begin
			cpuReadWord(cpuBase + 11'(3 * i), rd);
			check("cpuRdData", written[i], rd);
		end
		// Strobes outside the zone
		@(posedge CLK_24M);
		cpuZone <= 1'b0;
		acks = 0;
		for (i = 0; i < 102; i++)
		begin
			@(posedge CLK_24M);
			cpuWrite  <= (i < 32);
			cpuWrData <= 16'($random(seed));
			@(negedge CLK_24M);
			if (cpuWriteAck)
				acks++;
		end
		@(posedge CLK_24M);
		cpuZone <= 1'b1;
		check("cpuWriteAck count", 0, acks);
		cpuReadWord(cpuBase + 11'd27, rd); // Where the pointer sits now
		check("cpuRdData", written[9], rd);
		reportTest("cpu access", errBefore);
	endtask

	task automatic parserTest();
		int          errBefore;
		int          i;
		logic [7:0]  y;
		logic [15:0] rd;
		errBefore = errCount;
		for (i = 0; i < 5; i++)
		begin
			y = 8'd155 + 8'($random(seed) & 63); // 155..218, carry only at line 100
			cpuWriteWord(1'b1, spritePkg::scb3Base + 11'(hits[i]), yWord(y));
		end
		cpuWriteWord(1'b1, spritePkg::scb3Base + 11'd25, yWord(8'd154)); // One short
		startLine(9'd100, 1'b0);
		repeat (20 * 32) @(posedge CLK_24M);
		vCount <= 9'd0; // Line 0 matches nothing loaded
		for (i = 0; i < 5; i++)
		begin
			cpuReadWord(bank1 + 11'(i), rd);
			check("list $680", (i < 4) ? hits[i] : 0, rd); // Fifth hit has no partner
		end
		reportTest("parser match", errBefore);
	endtask

	task automatic bankSwapTest();
		int          errBefore;
		int          i;
		int          expLow [4];
		logic [15:0] rd;
		errBefore = errCount;
		startLine(9'd100, 1'b1);
		repeat (20 * 32) @(posedge CLK_24M);
		vCount <= 9'd0;
		for (i = 0; i < 5; i++)
		begin
			cpuReadWord(bank1 + 11'(i), rd);
			check("list $680", (i < 4) ? hits[i] : 0, rd);
		end
		// Leftover hit 41 pairs with the first hit of this line
		expLow[0] = hits[4];
		expLow[1] = hits[0];
		expLow[2] = hits[1];
		expLow[3] = hits[2];
		for (i = 0; i < 4; i++)
		begin
			cpuReadWord(spritePkg::listBase + 11'(i), rd);
			check("list $600", expLow[i], rd);
		end
		reportTest("bank swap", errBefore);
	endtask

	task automatic renderTest();
		int          errBefore;
		int          k;
		int          sprites [4] = '{5, 12, 33, 100};
		logic [15:0] scb2 [4];
		logic [15:0] scb3 [4];
		logic [15:0] scb4 [4];
		logic [8:0]  sum;
		errBefore = errCount;
		@(posedge CLK_24M);
		bFlip <= 1'b1; // Parser stays in $600 while the list goes to $680
		for (k = 0; k < 4; k++)
		begin
			scb2[k] = 16'($random(seed));
			scb3[k] = 16'($random(seed));
			scb4[k] = 16'($random(seed));
			cpuWriteWord(1'b1, spritePkg::scb2Base + 11'(sprites[k]), scb2[k]);
			cpuWriteWord(1'b1, spritePkg::scb3Base + 11'(sprites[k]), scb3[k]);
			cpuWriteWord(1'b1, spritePkg::scb4Base + 11'(sprites[k]), scb4[k]);
			cpuWriteWord(1'b1, bank1 + 11'(k), 16'(sprites[k]));
		end
		startLine(9'd200, 1'b1);
		for (k = 0; k < 4; k++)
		begin
			waitSlot(20); // Entry k done at slot 12
			sum = {1'b0, scb3[k][spritePkg::yLsb +: 8]} + 9'd201; // Y + line + 1
			check("renderIdx", sprites[k], renderIdx);
			check("attrShrink", scb2[k][spritePkg::shrinkBits-1:0], attrShrink);
			check("tileLine", sum[3:0], tileLine);
			check("tileIdx", {~sum[8], sum[7:4]}, tileIdx);
			check("attrXPos", scb4[k][15:spritePkg::xLsb], attrXPos);
		end
		reportTest("render fetch", errBefore);
	endtask

	initial
	begin
		#(watchdogNs);
		$display("watchdog expired, tests did not finish within %0d ns", watchdogNs);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		seed        = 10495;
		errCount    = 0;
		testsPassed = 0;
		testsFailed = 0;
		TEST        = 1'b1;
		vCount      = '0;
		chbl        = 1'b0;
		bFlip       = 1'b0;
		vramMod     = '0;
		reloadReq   = 1'b0;
		cpuAddr     = '0;
		cpuWrData   = '0;
		cpuZone     = 1'b1;
		cpuWrite    = 1'b0;
		repeat (4) @(posedge CLK_24M);
		TEST <= 1'b0;
		resetTest();
		cpuAccessTest();
		parserTest();
		bankSwapTest(); // Before render, which reuses $680
		renderTest();
		$display("%0d tests passed, %0d tests failed", testsPassed, testsFailed);
		if (testsFailed == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* fastCycle.f */
rtl/spritePkg.sv
rtl/fastVram.sv
rtl/slotSequencer.sv
rtl/spriteParser.sv
rtl/renderFetch.sv
rtl/cpuVramPort.sv
rtl/fastCycle.sv
verif/fastCycle_chk.sv
verif/fastCycleTb.sv

/* run.sh */
#!/bin/bash
# Compile with Verilator, run, then look for the fail line in the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module fastCycleTb -f fastCycle.f -o simFastCycle
./obj_dir/simFastCycle 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	echo "verdict: fail"
	exit 1
fi
echo "verdict: pass"
